/* logic/bus_pkg.sv */
/*
	system bus definitions
	- word and field widths
	- bus word and block number types
	- cycle kinds
	- address word union, memory and config views
*/

package bus_pkg;

	// ----------------------------------------------------------
	// widths
	// ----------------------------------------------------------

	// bus word, bit 0 is the msb
	localparam int WORD_W = 16;
	// block number (nb)
	localparam int NB_W = 4;
	// segment field at the top of the address
	localparam int SEG_W = 4;
	// word offset within a segment
	localparam int OFFSET_W = WORD_W - SEG_W;
	// frame field of a config word
	localparam int CFG_FRAME_W = 4;
	// bits between frame and detach, ignored
	localparam int CFG_PAD_W = WORD_W - SEG_W - CFG_FRAME_W - 1;

	// ----------------------------------------------------------
	// types
	// ----------------------------------------------------------

	typedef logic [0:WORD_W-1] word_t;
	typedef logic [0:NB_W-1] nb_t;

	// which strobe started the cycle
	typedef enum logic [1:0] {
		cyc_read  = 2'd0,
		cyc_write = 2'd1,
		cyc_cfg   = 2'd2
	} cycle_kind_t;

	// same 16 bits, meaning depends on the strobe
	typedef union packed {
		// r_ / w_ cycles
		struct packed {
			logic [0:SEG_W-1] seg;
			logic [0:OFFSET_W-1] offset;
		} mem;
		// s_ cycles
		struct packed {
			logic [0:SEG_W-1] seg;
			logic [0:CFG_FRAME_W-1] frame;
			logic [0:CFG_PAD_W-1] unused;
			logic detach;
		} cfg;
	} bus_addr_u;

endpackage

/* logic/mem_pkg.sv */
/*
	memory geometry
	- segment size and offset width
	- physical frame index
	- configuration map size and entry layout
*/

package mem_pkg;

	// ----------------------------------------------------------
	// frames and segments
	// ----------------------------------------------------------

	// one segment fills one physical frame
	localparam int SEG_WORDS = 4096;
	localparam int OFF_W = $clog2(SEG_WORDS);

	// up to 16 installed frames
	localparam int FRAME_W = 4;
	typedef logic [FRAME_W-1:0] frame_t;

	// ----------------------------------------------------------
	// configuration map
	// ----------------------------------------------------------

	// one entry per block and segment pair
	localparam int MAP_ENTRIES = 256;
	localparam int MAP_IDX_W = $clog2(MAP_ENTRIES);

	typedef struct packed {
		logic valid;
		frame_t frame;
	} map_entry_t;

endpackage

/* logic/strobe_sync.sv */
/*
	bus strobe synchronizer
	- two flop stages on w_, r_, s_
	- one request pulse per bus cycle, with its kind
	- idle level once all strobes read back high
*/

`timescale 1ns/1ps

module strobe_sync(
	input logic clk,
	input logic rst_n,
	input logic w_,
	input logic r_,
	input logic s_,
	output logic req,
	output bus_pkg::cycle_kind_t kind,
	output logic idle
);

	import bus_pkg::*;

	// strobe order in the vectors: w, r, s
	logic [2:0] meta;
	logic [2:0] sync;
	// idle as seen one cycle earlier
	logic idle_q;
	// first low cycle after all high
	logic start;
	cycle_kind_t kind_d;

	// first stage catches the async strobes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			meta <= 3'b111;
			sync <= 3'b111;
		end else begin
			meta <= {w_, r_, s_};
			sync <= meta;
		end
	end

	assign idle = &sync;
	assign start = idle_q && !idle;

	// only one strobe is low at a time on the bus
	always_comb begin
		if (!sync[1]) begin
			kind_d = cyc_read;
		end else if (!sync[2]) begin
			kind_d = cyc_write;
		end else begin
			kind_d = cyc_cfg;
		end
	end

	// req lands one edge after the second sync stage goes low
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idle_q <= 1'b1;
			req <= 1'b0;
			kind <= cyc_read;
		end else begin
			idle_q <= idle;
			req <= start;
			if (start) begin
				kind <= kind_d;
			end
		end
	end

endmodule

/* logic/mem_map.sv */
/*
	block/segment to frame configuration map
	- 256 entries indexed by nb and segment
	- combinational lookup for memory cycles
	- config check and update for s_ cycles
*/

`timescale 1ns/1ps

module mem_map #(
	parameter int FRAMES = 4
) (
	input logic clk,
	input logic rst_n,
	input bus_pkg::nb_t nb,
	input bus_pkg::bus_addr_u addr,
	input logic cfg_we,
	output logic hit,
	output mem_pkg::frame_t phys_frame,
	output logic cfg_ok
);

	import mem_pkg::*;

	// one entry per block and segment
	map_entry_t map [MAP_ENTRIES];

	logic [MAP_IDX_W-1:0] rd_idx;
	logic [MAP_IDX_W-1:0] wr_idx;
	map_entry_t rd_entry;

	// ----------------------------------------------------------
	// lookup
	// ----------------------------------------------------------

	// memory view of the address word
	assign rd_idx = {nb, addr.mem.seg};
	assign rd_entry = map[rd_idx];

	assign hit = rd_entry.valid;
	assign phys_frame = rd_entry.frame;

	// ----------------------------------------------------------
	// configuration
	// ----------------------------------------------------------

	// config view of the same word
	assign wr_idx = {nb, addr.cfg.seg};

	// detach always allowed
	// attach only to a frame that is installed
	assign cfg_ok = addr.cfg.detach || (int'(addr.cfg.frame) < FRAMES);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// nothing mapped after reset
			for (int i = 0; i < MAP_ENTRIES; i++) begin
				map[i].valid <= 1'b0;
			end
		end else if (cfg_we) begin
			if (addr.cfg.detach) begin
				map[wr_idx].valid <= 1'b0;
			end else begin
				map[wr_idx].valid <= 1'b1;
				map[wr_idx].frame <= addr.cfg.frame;
			end
		end
	end

endmodule

/* logic/word_ram.sv */
/*
	word storage
	- single port, one address for read and write
	- registered read
*/

`timescale 1ns/1ps

module word_ram #(
	parameter int DEPTH = 4096
) (
	input logic clk,
	input logic we,
	input logic [$clog2(DEPTH)-1:0] waddr,
	input bus_pkg::word_t wdata,
	output bus_pkg::word_t rdata
);

	import bus_pkg::*;

	// frames laid out back to back
	word_t mem [DEPTH];

	// read data valid one edge after the address
	// old contents come back on a write
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[waddr];
	end

endmodule

/* logic/mem_access.sv */
/*
	access sequencer
	- waiting / replying FSM
	- physical address from frame and offset
	- RAM write, map update and read-back per cycle kind
	- ok_ and rdt_ reply to the bus
*/

`timescale 1ns/1ps

module mem_access #(
	parameter int FRAMES = 4
) (
	input logic clk,
	input logic rst_n,
	input logic req,
	input bus_pkg::cycle_kind_t kind,
	input logic idle,
	input logic hit,
	input mem_pkg::frame_t phys_frame,
	input logic cfg_ok,
	input logic [mem_pkg::OFF_W-1:0] offset,
	input bus_pkg::word_t wdata,
	output logic cfg_we,
	output bus_pkg::word_t rdt_,
	output logic ok_
);

	import bus_pkg::*;
	import mem_pkg::*;

	localparam int DEPTH = FRAMES * SEG_WORDS;
	localparam int RAM_AW = $clog2(DEPTH);

	// FSM, low = waiting, high = replying
	logic replying;
	// reply belongs to a read cycle
	logic reading;
	logic accept;
	logic start;
	logic ram_we;
	logic [FRAME_W+OFF_W-1:0] live_addr;
	logic [RAM_AW-1:0] held_addr;
	logic [RAM_AW-1:0] ram_addr;
	word_t ram_rdata;

	// ----------------------------------------------------------
	// request decode
	// ----------------------------------------------------------

	// unmapped or bad config, stay silent
	assign accept = (kind == cyc_cfg) ? cfg_ok : hit;
	assign start = req && !replying && accept;

	// both commit on the edge that drops ok_
	assign ram_we = start && (kind == cyc_write);
	assign cfg_we = start && (kind == cyc_cfg);

	// frame picks the block of SEG_WORDS
	assign live_addr = {phys_frame, offset};

	// held address keeps read data steady through the reply
	assign ram_addr = replying ? held_addr : live_addr[RAM_AW-1:0];

	always_ff @(posedge clk) begin
		if (start) begin
			held_addr <= live_addr[RAM_AW-1:0];
		end
	end

	// ----------------------------------------------------------
	// FSM
	// ----------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			replying <= 1'b0;
			reading <= 1'b0;
		end else if (!replying) begin
			if (start) begin
				replying <= 1'b1;
				reading <= (kind == cyc_read);
			end
		end else if (idle) begin
			// strobe gone, end of cycle
			replying <= 1'b0;
			reading <= 1'b0;
		end
	end

	// bus side is active low
	assign ok_ = !replying;
	assign rdt_ = reading ? ~ram_rdata : '1;

	word_ram #(
		.DEPTH(DEPTH)
	) ram (
		.clk(clk),
		.we(ram_we),
		.waddr(ram_addr),
		.wdata(wdata),
		.rdata(ram_rdata)
	);

endmodule

/* logic/mem_unit.sv */
/*
	memory unit top level
	- system bus ports, memory side
	- strobe synchronizer, configuration map, access sequencer
*/

`timescale 1ns/1ps

module mem_unit #(
	parameter int FRAMES = 4
) (
	input logic clk,
	input logic rst_n,
	// system bus, active low
	input bus_pkg::nb_t nb_,
	input bus_pkg::word_t ad_,
	input bus_pkg::word_t ddt_,
	input logic w_,
	input logic r_,
	input logic s_,
	output bus_pkg::word_t rdt_,
	output logic ok_
);

	import bus_pkg::*;
	import mem_pkg::*;

	// strobe side
	logic req;
	cycle_kind_t kind;
	logic idle;
	// map side
	logic hit;
	frame_t phys_frame;
	logic cfg_ok;
	logic cfg_we;

	strobe_sync strobes (
		.clk(clk),
		.rst_n(rst_n),
		.w_(w_),
		.r_(r_),
		.s_(s_),
		.req(req),
		.kind(kind),
		.idle(idle)
	);

	// block and address words inverted on the way in
	mem_map #(
		.FRAMES(FRAMES)
	) map (
		.clk(clk),
		.rst_n(rst_n),
		.nb(~nb_),
		.addr(~ad_),
		.cfg_we(cfg_we),
		.hit(hit),
		.phys_frame(phys_frame),
		.cfg_ok(cfg_ok)
	);

	mem_access #(
		.FRAMES(FRAMES)
	) access (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.kind(kind),
		.idle(idle),
		.hit(hit),
		.phys_frame(phys_frame),
		.cfg_ok(cfg_ok),
		.offset(~ad_[SEG_W:WORD_W-1]),
		.wdata(~ddt_),
		.cfg_we(cfg_we),
		.rdt_(rdt_),
		.ok_(ok_)
	);

endmodule

/* testbench/mem_unit_properties.sv */
/*
	bus reply assertions, bound into the memory unit
	- ok_ only after a strobe
	- rdt_ idle while ok_ is high
	- ok_ fall and rise latency
	- running count of failed assertions
*/

`timescale 1ns/1ps

module mem_unit_properties(
	input logic clk,
	input logic rst_n,
	input logic w_,
	input logic r_,
	input logic s_,
	input logic ok_,
	input bus_pkg::word_t rdt_
);

	// some strobe low on the bus
	logic any_low;
	int fail_count = 0;

	assign any_low = !w_ || !r_ || !s_;

	// reply only while a strobe was low the cycle before
	reply_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(ok_) |-> $past(any_low))
		else begin
			fail_count++;
			$error("ok_ fell with no strobe low");
		end

	// read data only during the reply
	rdt_idle: assert property (@(posedge clk) disable iff (!rst_n)
		ok_ |-> (rdt_ == '1))
		else begin
			fail_count++;
			$error("rdt_ not all ones while ok_ high");
		end

	// strobe seen low at edge 1, ok_ low after edge 4
	fall_latency: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(ok_) |-> ($past(any_low, 4) && !$past(any_low, 5)))
		else begin
			fail_count++;
			$error("ok_ fell at the wrong distance from the strobe");
		end

	// release seen at edge 1, ok_ high after edge 3
	rise_latency: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ok_) |-> (!$past(any_low, 3) && $past(any_low, 4)))
		else begin
			fail_count++;
			$error("ok_ rose at the wrong distance from the release");
		end

endmodule

/* testbench/mem_unit_tb.sv */
/*
	memory unit testbench
	- table of bus cycles applied in a loop
	- reply, read data and release checks
	- watchdog and closing summary
*/

`timescale 1ns/1ps

module mem_unit_tb;

	import bus_pkg::*;

	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	// longest wait for an ok_ edge
	localparam int WAIT_CYCLES = 10;
	localparam int MAX_STEPS = 32;

	logic clk = 1'b0;
	logic rst_n;
	nb_t nb_;
	word_t ad_;
	word_t ddt_;
	logic w_;
	logic r_;
	logic s_;
	word_t rdt_;
	logic ok_;

	// stimulus table, one array per column
	cycle_kind_t step_kind [MAX_STEPS];
	logic [3:0] step_nb [MAX_STEPS];
	logic [15:0] step_addr [MAX_STEPS];
	logic [15:0] step_data [MAX_STEPS];
	logic step_reply [MAX_STEPS];
	logic [15:0] step_expect [MAX_STEPS];
	// extra cycles the strobe stays low after ok_
	int step_hold [MAX_STEPS];
	int n_steps = 0;
	logic table_ready = 1'b0;

	int n_checks = 0;
	int n_errors = 0;
	integer seed;

	mem_unit #(.FRAMES(4)) uut (.*);

	bind mem_unit mem_unit_properties props (
		.clk(clk), .rst_n(rst_n), .w_(w_), .r_(r_), .s_(s_),
		.ok_(ok_), .rdt_(rdt_)
	);

	always #(PERIOD / 2) clk = ~clk;

	// memory view, segment on top of the offset
	function automatic logic [15:0] mem_word(input logic [3:0] seg, input logic [11:0] off);
		return {seg, off};
	endfunction

	// config view, detach in the last bit
	function automatic logic [15:0] cfg_word(input logic [3:0] seg, input logic [3:0] frame,
			input logic detach);
		return {seg, frame, 7'b0, detach};
	endfunction

	task automatic add_step(input cycle_kind_t kind, input logic [3:0] nb,
			input logic [15:0] addr, input logic [15:0] data, input logic reply,
			input logic [15:0] rd_value, input int hold);
		step_kind[n_steps] = kind;
		step_nb[n_steps] = nb;
		step_addr[n_steps] = addr;
		step_data[n_steps] = data;
		step_reply[n_steps] = reply;
		step_expect[n_steps] = rd_value;
		step_hold[n_steps] = hold;
		n_steps++;
	endtask

	task automatic build_table();
		logic [15:0] d [5];
		for (int k = 0; k < 5; k++) begin
			d[k] = 16'($random(seed));
		end
		// nothing mapped yet
		add_step(cyc_read, 4'h1, mem_word(4'h2, 12'h010), 16'h0, 1'b0, 16'h0, 0);
		add_step(cyc_write, 4'h1, mem_word(4'h2, 12'h010), d[0], 1'b0, 16'h0, 0);
		add_step(cyc_read, 4'h0, mem_word(4'h0, 12'h000), 16'h0, 1'b0, 16'h0, 0);
		// nb 1 seg 2 on frame 2
		add_step(cyc_cfg, 4'h1, cfg_word(4'h2, 4'h2, 1'b0), 16'h0, 1'b1, 16'h0, 0);
		add_step(cyc_write, 4'h1, mem_word(4'h2, 12'h010), d[0], 1'b1, 16'h0, 0);
		add_step(cyc_write, 4'h1, mem_word(4'h2, 12'hfff), d[1], 1'b1, 16'h0, 0);
		add_step(cyc_read, 4'h1, mem_word(4'h2, 12'h010), 16'h0, 1'b1, d[0], 0);
		add_step(cyc_read, 4'h1, mem_word(4'h2, 12'hfff), 16'h0, 1'b1, d[1], 0);
		// same segment under another block stays unmapped
		add_step(cyc_read, 4'h2, mem_word(4'h2, 12'h010), 16'h0, 1'b0, 16'h0, 0);
		// two pairs share frame 1
		add_step(cyc_cfg, 4'h3, cfg_word(4'h5, 4'h1, 1'b0), 16'h0, 1'b1, 16'h0, 0);
		add_step(cyc_cfg, 4'h6, cfg_word(4'ha, 4'h1, 1'b0), 16'h0, 1'b1, 16'h0, 0);
		add_step(cyc_write, 4'h3, mem_word(4'h5, 12'h123), d[2], 1'b1, 16'h0, 0);
		add_step(cyc_read, 4'h6, mem_word(4'ha, 12'h123), 16'h0, 1'b1, d[2], 0);
		add_step(cyc_write, 4'h6, mem_word(4'ha, 12'h124), d[3], 1'b1, 16'h0, 0);
		add_step(cyc_read, 4'h3, mem_word(4'h5, 12'h124), 16'h0, 1'b1, d[3], 0);
		// frame 1 and frame 2 kept apart at the same offset
		add_step(cyc_write, 4'h6, mem_word(4'ha, 12'h010), ~d[0], 1'b1, 16'h0, 0);
		add_step(cyc_read, 4'h1, mem_word(4'h2, 12'h010), 16'h0, 1'b1, d[0], 0);
		// frames 4 and up are not installed
		add_step(cyc_cfg, 4'h2, cfg_word(4'h4, 4'h4, 1'b0), 16'h0, 1'b0, 16'h0, 0);
		add_step(cyc_cfg, 4'h2, cfg_word(4'h4, 4'hf, 1'b0), 16'h0, 1'b0, 16'h0, 0);
		add_step(cyc_read, 4'h2, mem_word(4'h4, 12'h000), 16'h0, 1'b0, 16'h0, 0);
		// detach answers whatever the frame field holds
		add_step(cyc_cfg, 4'h3, cfg_word(4'h5, 4'h9, 1'b1), 16'h0, 1'b1, 16'h0, 0);
		add_step(cyc_read, 4'h3, mem_word(4'h5, 12'h123), 16'h0, 1'b0, 16'h0, 0);
		add_step(cyc_read, 4'h6, mem_word(4'ha, 12'h123), 16'h0, 1'b1, d[2], 0);
		// strobes held long, then a normal cycle
		add_step(cyc_write, 4'h1, mem_word(4'h2, 12'h200), d[4], 1'b1, 16'h0, 40);
		add_step(cyc_read, 4'h1, mem_word(4'h2, 12'h200), 16'h0, 1'b1, d[4], 25);
		add_step(cyc_read, 4'h1, mem_word(4'h2, 12'h010), 16'h0, 1'b1, d[0], 0);
	endtask

	// one bus cycle, entered and left on a falling edge
	task automatic run_step(input int i);
		int waited;
		word_t want_rdt;
		waited = 0;
		// bus shows the stored word inverted
		want_rdt = (step_reply[i] && step_kind[i] == cyc_read) ? ~step_expect[i] : '1;
		nb_ = ~step_nb[i];
		ad_ = ~step_addr[i];
		ddt_ = ~step_data[i];
		r_ = (step_kind[i] != cyc_read);
		w_ = (step_kind[i] != cyc_write);
		s_ = (step_kind[i] != cyc_cfg);
		while (ok_ && waited < WAIT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		repeat (step_hold[i]) @(negedge clk);
		n_checks++;
		if (ok_ !== !step_reply[i]) begin
			n_errors++;
			$display("Error: step %0d ok_ expected %h got %h", i, !step_reply[i], ok_);
		end
		n_checks++;
		if (rdt_ !== want_rdt) begin
			n_errors++;
			$display("Error: step %0d rdt_ expected %h got %h", i, want_rdt, rdt_);
		end
		// release and wait for the reply to drop
		{w_, r_, s_} = 3'b111;
		waited = 0;
		while (!ok_ && waited < WAIT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		n_checks++;
		if (!ok_) begin
			n_errors++;
			$display("step %0d: ok_ still low %0d cycles after strobe release", i, waited);
		end
		// idle bus so the synchronizer sees all strobes high
		repeat (4) @(negedge clk);
	endtask

	initial begin
		seed = 32'h1a79;
		rst_n = 1'b0;
		nb_ = '1;
		ad_ = '1;
		ddt_ = '1;
		w_ = 1'b1;
		r_ = 1'b1;
		s_ = 1'b1;
		build_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		repeat (4) @(negedge clk);
		for (int i = 0; i < n_steps; i++) begin
			run_step(i);
		end
		n_errors = n_errors + uut.props.fail_count;
		$display("steps %0d, checks %0d, errors %0d", n_steps, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// run limit scales with the table
	initial begin
		wait (table_ready);
		repeat (n_steps * 30 + RESET_CYCLES) @(posedge clk);
		$display("watchdog expired, %0d table steps did not finish in time", n_steps);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* filelist.f */
logic/bus_pkg.sv
logic/mem_pkg.sv
logic/strobe_sync.sv
logic/mem_map.sv
logic/word_ram.sv
logic/mem_access.sv
logic/mem_unit.sv
testbench/mem_unit_properties.sv
testbench/mem_unit_tb.sv

/* Makefile */
# Verilator build and run of the memory unit testbench

VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP := mem_unit_tb
FILELIST := filelist.f
OBJ_DIR := obj_dir
PASS_MSG := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
